//--- hdl/mul_types_pkg.sv
// Datapath types shared by the multiplier and its surroundings
package mul_types_pkg;

	// Width of each unsigned operand
	localparam int OPERAND_WIDTH = 32;

	// Full product width, no truncation
	localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

	// Operand pair as offered on the input handshake
	// a is the multiplicand, b the multiplier
	typedef struct packed {
		// Multiplicand, shifted left during the calculation
		logic [OPERAND_WIDTH-1:0] a;
		// Multiplier, scanned from its low bit upward
		logic [OPERAND_WIDTH-1:0] b;
	} mul_operands_t;

	// Product as held on the output side
	// Also the width of the shifting multiplicand register
	typedef logic [PRODUCT_WIDTH-1:0] mul_product_t;

endpackage

//--- hdl/mul_ctrl_pkg.sv
// Control encoding between the controller and the datapath
package mul_ctrl_pkg;

	// One shift-add step per multiplier bit
	localparam int STEP_COUNT = 32;

	// Counter must hold 0 through STEP_COUNT inclusive
	localparam int STEP_COUNT_WIDTH = 6;

	// Controller states
	typedef enum logic [1:0] {
		// Waiting for an operand pair with in_ready high
		STATE_IDLE = 2'd0,
		// Running the shift-add steps
		STATE_CALC = 2'd1,
		// Holding the product until ack
		STATE_DONE = 2'd2
	} mul_state_t;

	// Control word driven to the datapath every cycle
	typedef struct packed {
		// Capture operands and clear the accumulator
		logic load;
		// Shift multiplicand left and multiplier right
		logic step;
		// Add the multiplicand to the accumulator on this step
		logic add_en;
	} mul_ctrl_t;

endpackage

//--- hdl/shift_add_ctrl.sv
`timescale 1ns/1ps

// Controller of the shift-and-add multiplier
// Moore FSM idle -> calc -> done -> idle
// Valid/ready on the operand side, done/ack on the product side
module shift_add_ctrl
(
	input logic Clock,
	input logic Reset,

	// Operand side
	input logic in_valid,
	output logic in_ready,

	// Product side
	input logic ack,
	output logic out_valid,

	// Low bit of the shifting multiplier, from the datapath
	input logic b_lsb,

	// Control word to the datapath
	output mul_ctrl_pkg::mul_ctrl_t ctrl
);

	// Counter type, sized to hold STEP_COUNT itself
	typedef logic [mul_ctrl_pkg::STEP_COUNT_WIDTH-1:0] step_cnt_t;

	// Current and next state
	mul_ctrl_pkg::mul_state_t state;
	mul_ctrl_pkg::mul_state_t next_state;

	// Number of steps done in the current calculation
	step_cnt_t step_cnt;

	// High in the calc cycle whose step completes the product
	logic last_step;

	// Operand pair taken on this edge
	logic accept;

	// Transfer happens only while idle
	assign in_ready = (state == mul_ctrl_pkg::STATE_IDLE);
	assign accept = in_valid && in_ready;

	// Step that moves the count from STEP_COUNT-1 to STEP_COUNT
	assign last_step = (state == mul_ctrl_pkg::STATE_CALC)
		&& (step_cnt == step_cnt_t'(mul_ctrl_pkg::STEP_COUNT - 1));

	// State, counter and output flag registers
	always_ff @(posedge Clock, posedge Reset)
	begin
		if (Reset)
		begin
			state <= mul_ctrl_pkg::STATE_IDLE;
			step_cnt <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			state <= next_state;

			// Registered flag, rises together with the done state
			out_valid <= (next_state == mul_ctrl_pkg::STATE_DONE);

			// Cleared on acceptance, counts every step
			// Stays at STEP_COUNT through done
			if (ctrl.load)
			begin
				step_cnt <= '0;
			end
			else if (ctrl.step)
			begin
				step_cnt <= step_cnt + step_cnt_t'(1);
			end
		end
	end

	// Next state logic
	always_comb
	begin
		// Hold by default
		next_state = state;

		case (state)
			mul_ctrl_pkg::STATE_IDLE:
			begin
				// Leave idle on the acceptance edge
				if (accept)
				begin
					next_state = mul_ctrl_pkg::STATE_CALC;
				end
			end

			mul_ctrl_pkg::STATE_CALC:
			begin
				// 32 steps, no early exit on a zero multiplier
				if (last_step)
				begin
					next_state = mul_ctrl_pkg::STATE_DONE;
				end
			end

			mul_ctrl_pkg::STATE_DONE:
			begin
				// Product held until the consumer takes it
				if (ack)
				begin
					next_state = mul_ctrl_pkg::STATE_IDLE;
				end
			end

			default:
			begin
				// Unused encoding falls back to idle
				next_state = mul_ctrl_pkg::STATE_IDLE;
			end
		endcase
	end

	// Control word
	always_comb
	begin
		// Load on acceptance, operands captured on that same edge
		ctrl.load = accept;

		// Every calc cycle is one step
		ctrl.step = (state == mul_ctrl_pkg::STATE_CALC);

		// Add only when the bit under inspection is set
		ctrl.add_en = ctrl.step && b_lsb;
	end

	// Counter stays within 0 .. STEP_COUNT for the whole run
	a_cnt_range: assert property (@(posedge Clock) disable iff (Reset)
		step_cnt <= step_cnt_t'(mul_ctrl_pkg::STEP_COUNT));

	// Registered done flag never runs ahead of or behind the state
	a_valid_in_done: assert property (@(posedge Clock) disable iff (Reset)
		out_valid |-> (state == mul_ctrl_pkg::STATE_DONE));

	// Datapath never sees a load and a shift in one cycle
	a_load_step_excl: assert property (@(posedge Clock) disable iff (Reset)
		!(ctrl.load && ctrl.step));

endmodule

//--- hdl/shift_add_datapath.sv
`timescale 1ns/1ps

// Datapath of the shift-and-add multiplier
// Multiplicand shifts left, multiplier shifts right,
// accumulator adds the multiplicand when the low multiplier bit is set
module shift_add_datapath
(
	input logic Clock,
	input logic Reset,

	// Control word from the controller
	input mul_ctrl_pkg::mul_ctrl_t ctrl,

	// Operand pair, sampled on load
	input mul_types_pkg::mul_operands_t operands,

	// Low bit of the shifting multiplier
	output logic b_lsb,

	// Accumulated product
	output mul_types_pkg::mul_product_t product
);

	// Multiplicand, full product width so no bit falls off the top
	mul_types_pkg::mul_product_t multiplicand;

	// Multiplier, consumed one bit per step from the bottom
	logic [mul_types_pkg::OPERAND_WIDTH-1:0] multiplier;

	// Product accumulator
	mul_types_pkg::mul_product_t product_q;

	// Sum for the current step
	mul_types_pkg::mul_product_t sum;

	// Adder sees the multiplicand before this step's shift
	assign sum = product_q + multiplicand;

	// Operand shift registers
	always_ff @(posedge Clock)
	begin
		if (ctrl.load)
		begin
			// Zero-extend a into the upper half
			multiplicand <= mul_types_pkg::mul_product_t'(operands.a);
			multiplier <= operands.b;
		end
		else if (ctrl.step)
		begin
			// Next bit weight
			multiplicand <= multiplicand << 1;
			// Next multiplier bit moves into bit 0
			multiplier <= multiplier >> 1;
		end
	end

	// Accumulator
	always_ff @(posedge Clock, posedge Reset)
	begin
		if (Reset)
		begin
			product_q <= '0;
		end
		else if (ctrl.load)
		begin
			// Fresh start for the new pair
			product_q <= '0;
		end
		else if (ctrl.step && ctrl.add_en)
		begin
			product_q <= sum;
		end
	end

	// Feedback for the controller's add decision
	assign b_lsb = multiplier[0];

	// Result straight from the accumulator
	assign product = product_q;

	// Outside load and step the product is frozen, which covers the done hold
	a_product_hold: assert property (@(posedge Clock) disable iff (Reset)
		(!ctrl.load && !ctrl.step) |=> $stable(product));

endmodule

//--- hdl/shift_add_multiplier.sv
`timescale 1ns/1ps

// Unsigned 32 x 32 shift-and-add multiplier
// One product in flight, 32 cycles from acceptance to out_valid
module shift_add_multiplier
(
	input logic Clock,
	input logic Reset,

	// Operand side, valid/ready
	input logic in_valid,
	output logic in_ready,
	input mul_types_pkg::mul_operands_t operands,

	// Product side, held until ack
	output logic out_valid,
	input logic ack,
	output mul_types_pkg::mul_product_t product
);

	// Control word from controller to datapath
	mul_ctrl_pkg::mul_ctrl_t ctrl;

	// Current multiplier bit back to the controller
	logic b_lsb;

	// Sequencing and both handshakes
	shift_add_ctrl u_ctrl
	(
		.Clock (Clock),
		.Reset (Reset),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.ack (ack),
		.out_valid (out_valid),
		.b_lsb (b_lsb),
		.ctrl (ctrl)
	);

	// Operand registers and accumulator
	shift_add_datapath u_datapath
	(
		.Clock (Clock),
		.Reset (Reset),
		.ctrl (ctrl),
		.operands (operands),
		.b_lsb (b_lsb),
		.product (product)
	);

endmodule

//--- bench/multiplier_tb.sv
`timescale 1ns/1ps

// Testbench for the shift-and-add multiplier
// A cycle model tracks busy time and the expected product for the assertions
module multiplier_tb;

	// Latency from acceptance edge to out_valid, in cycles
	localparam int LATENCY = 32;
	localparam int DIRECTED_COUNT = 8;
	localparam int RANDOM_COUNT = 200;
	// Directed and random pairs plus two for the busy test and one for back-pressure
	localparam int TXN_COUNT = DIRECTED_COUNT + RANDOM_COUNT + 3;
	// Per transaction 32 + 8 + 4 cycles of 20 ns plus 1 us slack
	localparam int WATCHDOG_NS = TXN_COUNT * (32 + 8 + 4) * 20 + 1000;
	localparam logic [31:0] RAND_SEED = 32'ha1cc_1df6;

	logic Clock;
	logic Reset;
	logic in_valid;
	logic in_ready;
	mul_types_pkg::mul_operands_t operands;
	logic out_valid;
	logic ack;
	mul_types_pkg::mul_product_t product;

	// Model state
	logic busy;
	int cyc;
	mul_types_pkg::mul_product_t exp_product;
	logic exp_valid;

	// Bookkeeping
	string test_name;
	int err_count;
	int err_at_start;
	int tests_passed;
	int tests_failed;

	// Directed operand pairs
	logic [31:0] dir_a [DIRECTED_COUNT];
	logic [31:0] dir_b [DIRECTED_COUNT];

	shift_add_multiplier dut
	(
		.Clock (Clock),
		.Reset (Reset),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.operands (operands),
		.out_valid (out_valid),
		.ack (ack),
		.product (product)
	);

	// 20 ns clock
	initial
	begin
		Clock = 1'b0;
	end

	always
	begin
		#10 Clock = ~Clock;
	end

	// Reference model fed only by the inputs and its own state
	always @(posedge Clock, posedge Reset)
	begin
		if (Reset)
		begin
			busy <= 1'b0;
			cyc <= 0;
			exp_product <= '0;
		end
		else if (in_valid && !busy)
		begin
			// Full unsigned product taken on the acceptance edge
			busy <= 1'b1;
			cyc <= 0;
			exp_product <= mul_types_pkg::mul_product_t'(operands.a)
				* mul_types_pkg::mul_product_t'(operands.b);
		end
		else if (busy)
		begin
			if (cyc == LATENCY && ack)
			begin
				busy <= 1'b0;
			end
			else if (cyc < LATENCY)
			begin
				cyc <= cyc + 1;
			end
		end
	end

	// Product is due once LATENCY edges have passed
	assign exp_valid = busy && (cyc == LATENCY);

	// Ready exactly while the model is idle
	a_ready: assert property (@(posedge Clock) disable iff (Reset)
		in_ready == !busy)
	else
	begin
		err_count++;
		$display("[FAIL] %s: in_ready expected %b actual %b",
			test_name, !$sampled(busy), $sampled(in_ready));
	end

	// Covers reset state, latency, hold and the fall on ack
	a_valid: assert property (@(posedge Clock) disable iff (Reset)
		out_valid == exp_valid)
	else
	begin
		err_count++;
		$display("[FAIL] %s: out_valid expected %b actual %b",
			test_name, $sampled(exp_valid), $sampled(out_valid));
	end

	// Product value against the model
	a_product: assert property (@(posedge Clock) disable iff (Reset)
		out_valid |-> (product == exp_product))
	else
	begin
		err_count++;
		$display("[FAIL] %s: product expected %h actual %h",
			test_name, $sampled(exp_product), $sampled(product));
	end

	// No change while the consumer holds off
	a_hold: assert property (@(posedge Clock) disable iff (Reset)
		(out_valid && !ack) |=> $stable(product))
	else
	begin
		err_count++;
		$display("Error in %s: product changed while waiting for ack", test_name);
	end

	task automatic start_test(input string name);
		test_name = name;
		err_at_start = err_count;
	endtask

	task automatic end_test();
		if (err_count == err_at_start)
		begin
			tests_passed++;
			$display("test %-12s ok", test_name);
		end
		else
		begin
			tests_failed++;
			$display("test %-12s %0d errors", test_name, err_count - err_at_start);
		end
	endtask

	// Offer a pair and hold it until it is taken
	task automatic offer_pair(input logic [31:0] a, input logic [31:0] b);
		@(negedge Clock);
		in_valid = 1'b1;
		operands.a = a;
		operands.b = b;
		// in_ready is stable at the falling edge
		while (!in_ready)
		begin
			@(negedge Clock);
		end
		@(negedge Clock);
		in_valid = 1'b0;
		// Junk on the bus that the DUT must ignore
		operands = {$urandom, $urandom};
	endtask

	// Wait for the product and acknowledge it after a delay
	task automatic take_product(input int delay);
		while (!out_valid)
		begin
			@(negedge Clock);
		end
		repeat (delay)
		begin
			@(negedge Clock);
		end
		ack = 1'b1;
		@(negedge Clock);
		ack = 1'b0;
	endtask

	task automatic multiply(input logic [31:0] a, input logic [31:0] b, input int delay);
		offer_pair(a, b);
		take_product(delay);
	endtask

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, DUT stopped responding", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(RAND_SEED));
		in_valid = 1'b0;
		ack = 1'b0;
		operands = '0;
		Reset = 1'b1;
		err_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_name = "reset";
		err_at_start = 0;

		// Zero, one, all ones and single bits incl. top bit of b
		dir_a = '{32'h0000_0000, 32'hdead_beef, 32'h0000_0001, 32'h8765_4321,
			32'hffff_ffff, 32'h8000_0000, 32'h0000_0001, 32'h0001_0000};
		dir_b = '{32'h1234_5678, 32'h0000_0000, 32'hcafe_f00d, 32'h0000_0001,
			32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h0000_0100};

		repeat (2)
		begin
			@(negedge Clock);
		end
		Reset = 1'b0;

		// Idle inputs keep ready high and valid low throughout
		start_test("reset");
		repeat (6)
		begin
			@(negedge Clock);
		end
		end_test();

		start_test("directed");
		for (int i = 0; i < DIRECTED_COUNT; i++)
		begin
			multiply(dir_a[i], dir_b[i], $urandom_range(0, 7));
		end
		end_test();

		start_test("random");
		for (int i = 0; i < RANDOM_COUNT; i++)
		begin
			multiply($urandom, $urandom, $urandom_range(0, 7));
		end
		end_test();

		// Long ack delay keeps the hold checks running for many cycles
		start_test("backpressure");
		multiply(32'h0bad_cafe, 32'h7fff_0001, 12);
		end_test();

		// Second pair waits while the first is computed
		start_test("busy");
		offer_pair(32'h1357_9bdf, 32'h2468_ace0);
		// Stray ack during calc is ignored
		ack = 1'b1;
		@(negedge Clock);
		ack = 1'b0;
		fork
			offer_pair(32'hfedc_ba98, 32'h0f0f_0f0f);
			take_product($urandom_range(0, 7));
		join
		take_product($urandom_range(0, 7));
		end_test();

		// Let last assertions settle
		repeat (3)
		begin
			@(negedge Clock);
		end

		$display("tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0)
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
hdl/mul_types_pkg.sv
hdl/mul_ctrl_pkg.sv
hdl/shift_add_ctrl.sv
hdl/shift_add_datapath.sv
hdl/shift_add_multiplier.sv
bench/multiplier_tb.sv
